// File: vlog.f
+incdir+sim
verilog/i2c_cfg_pkg.sv
verilog/i2c_data_pkg.sv
verilog/i2c_line_filter.sv
verilog/i2c_slave_engine.sv
verilog/word_fifo.sv
verilog/i2c_slave_top.sv
sim/i2c_slave_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --top-module i2c_slave_tb -f vlog.f -o simv
	./obj_dir/simv > sim.log 2>&1; cat sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: sim/i2c_master_tasks.svh
`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

// ------------------------------
// Random numbers
// ------------------------------
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32 22 2 1
endfunction

task automatic rand_bits(input int n, output logic [31:0] v);
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
endtask

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_word(input string name, input i2c_data_pkg::word_t exp,
		input i2c_data_pkg::word_t got);
	if (got !== exp) begin
		mismatch_cnt++;
		$display("mismatch %s: expected %h, got %h", name, exp, got);
	end
endtask

task automatic check_ack(input string name, input logic exp, input logic got);
	if (got !== exp) begin
		mismatch_cnt++;
		$display("mismatch %s: expected %h, got %h", name, exp, got);
	end
endtask

task automatic check_pulse(input string name, input logic exp, input logic got);
	if (got !== exp) begin
		mismatch_cnt++;
		$display("mismatch %s: expected %h, got %h", name, exp, got);
	end
endtask

// ------------------------------
// Bit-banged master
// ------------------------------
task automatic wait_clks(input int n);
	repeat (n) @(posedge clk);
endtask

// Works from idle and as repeated START with SCL low
task automatic bus_start();
	sda_m <= 1'b1;
	wait_clks(HALF / 2);
	scl_m <= 1'b1;
	wait_clks(HALF);
	sda_m <= 1'b0;
	wait_clks(HALF);
	scl_m <= 1'b0;
	wait_clks(HALF / 2);
endtask

task automatic bus_stop();
	sda_m <= 1'b0;
	wait_clks(HALF / 2);
	scl_m <= 1'b1;
	wait_clks(HALF);
	sda_m <= 1'b1;
	wait_clks(HALF);
endtask

task automatic write_bit(input logic b);
	sda_m <= b;
	wait_clks(HALF / 2);
	scl_m <= 1'b1;
	wait_clks(HALF);
	scl_m <= 1'b0;
	wait_clks(HALF / 2);
endtask

task automatic read_bit(output logic b);
	sda_m <= 1'b1;
	wait_clks(HALF / 2);
	scl_m <= 1'b1;
	wait_clks(HALF / 2);
	b = sda_bus; // Middle of SCL high
	wait_clks(HALF / 2);
	scl_m <= 1'b0;
	wait_clks(HALF / 2);
endtask

task automatic write_byte(input logic [7:0] d, output logic ack_n);
	for (int i = 7; i >= 0; i--)
		write_bit(d[i]);
	read_bit(ack_n);
endtask

task automatic read_byte(output logic [7:0] d, input logic nack);
	logic b;
	for (int i = 7; i >= 0; i--) begin
		read_bit(b);
		d[i] = b;
	end
	write_bit(nack);
endtask

`endif

// File: sim/i2c_slave_tb.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_tb;

	typedef logic [7:0] byte_t;

	localparam int HALF = 64; // SCL half period in clocks
	localparam logic [6:0] OWN = 7'h2a;

	logic clk = 1'b0;
	logic rst;
	logic scl_m;
	logic sda_m;
	logic sda_bus;
	logic [6:0] own_addr;
	logic rx_pop;
	logic tx_push;
	i2c_data_pkg::word_t tx_word;
	i2c_data_pkg::word_t rx_word;
	logic rx_empty;
	logic tx_full;
	logic sda_oe;
	logic wr_done;
	logic rd_done;
	logic rd_err;

	logic [31:0] lfsr_state = 32'hcff9;
	int mismatch_cnt = 0;
	int timeout_cnt = 0;
	int wr_pulses = 0;
	int rd_pulses = 0;
	int err_pulses = 0;

	`include "i2c_master_tasks.svh"

	always #50 clk = ~clk;

	// Wired-AND of master and target
	assign sda_bus = sda_m & ~sda_oe;

	i2c_slave_top uut (
		.clk        (clk),
		.rst        (rst),
		.scl_i      (scl_m),
		.sda_i      (sda_bus),
		.sda_oe_o   (sda_oe),
		.own_addr_i (own_addr),
		.rx_pop_i   (rx_pop),
		.rx_word_o  (rx_word),
		.rx_empty_o (rx_empty),
		.tx_push_i  (tx_push),
		.tx_word_i  (tx_word),
		.tx_full_o  (tx_full),
		.wr_done_o  (wr_done),
		.rd_done_o  (rd_done),
		.rd_err_o   (rd_err)
	);

	always @(posedge clk) begin
		if (wr_done) wr_pulses++;
		if (rd_done) rd_pulses++;
		if (rd_err) err_pulses++;
	end

	// Reference: bus bytes to words, first byte on top, tail dropped
	function automatic void pack_words(input byte_t bytes[$],
			output i2c_data_pkg::word_t words[$]);
		i2c_data_pkg::word_t w;
		words = {};
		for (int i = 0; i + i2c_data_pkg::BYTES_PER_WORD <= bytes.size();
				i += i2c_data_pkg::BYTES_PER_WORD) begin
			w = '0;
			for (int k = 0; k < i2c_data_pkg::BYTES_PER_WORD; k++)
				w = {w[23:0], bytes[i + k]};
			words.push_back(w);
		end
	endfunction

	function automatic int pulse_count(input int which);
		case (which)
			0: return wr_pulses;
			1: return rd_pulses;
			default: return err_pulses;
		endcase
	endfunction

	task automatic wait_pulse(input int which, input int base, input string what);
		for (int t = 0; t < 200 && pulse_count(which) == base; t++)
			@(posedge clk);
		if (pulse_count(which) == base) begin
			timeout_cnt++;
			$display("timeout: no %s pulse seen", what);
		end
	endtask

	// ------------------------------
	// Host side
	// ------------------------------
	task automatic expect_rx(input i2c_data_pkg::word_t exp);
		for (int t = 0; t < 50 && rx_empty; t++)
			@(posedge clk);
		if (rx_empty) begin
			timeout_cnt++;
			$display("timeout: receive FIFO stayed empty");
		end else begin
			check_word("rx_word_o", exp, rx_word);
			rx_pop <= 1'b1;
			@(posedge clk);
			rx_pop <= 1'b0;
			@(posedge clk);
		end
	endtask

	task automatic push_tx(input i2c_data_pkg::word_t w);
		tx_word <= w;
		tx_push <= 1'b1;
		@(posedge clk);
		tx_push <= 1'b0;
		@(posedge clk);
	endtask

	task automatic random_bytes(input int n, output byte_t q[$]);
		logic [31:0] v;
		q = {};
		for (int i = 0; i < n; i++) begin
			rand_bits(8, v);
			q.push_back(v[7:0]);
		end
	endtask

	// ------------------------------
	// Bus transactions
	// ------------------------------
	task automatic write_trans(input logic [6:0] addr, input byte_t data[$],
			input logic exp_ack, input logic do_stop);
		logic ack_n;
		bus_start();
		write_byte({addr, 1'b0}, ack_n);
		check_ack("write address ack", ~exp_ack, ack_n);
		if (exp_ack) begin
			foreach (data[i]) begin
				write_byte(data[i], ack_n);
				check_ack("write data ack", 1'b0, ack_n);
			end
		end
		if (do_stop)
			bus_stop();
	endtask

	task automatic read_trans(input int n, output byte_t got[$]);
		logic ack_n;
		byte_t b;
		got = {};
		bus_start();
		write_byte({OWN, 1'b1}, ack_n);
		check_ack("read address ack", 1'b0, ack_n);
		for (int i = 0; i < n; i++) begin
			read_byte(b, i == n - 1); // NACK on the last byte
			got.push_back(b);
		end
		bus_stop();
	endtask

	// ------------------------------
	// Scenarios
	// ------------------------------
	initial begin
		byte_t bytes[$];
		byte_t got[$];
		i2c_data_pkg::word_t exp[$];
		i2c_data_pkg::word_t sent[$];
		i2c_data_pkg::word_t w;
		logic ack_n;
		int base;

		rst = 1'b1;
		scl_m = 1'b1;
		sda_m = 1'b1;
		own_addr = OWN;
		rx_pop = 1'b0;
		tx_push = 1'b0;
		tx_word = '0;
		wait_clks(5);
		rst <= 1'b0;
		wait_clks(10);

		// Write to own address
		random_bytes(8, bytes);
		base = wr_pulses;
		write_trans(OWN, bytes, 1'b1, 1'b1);
		wait_pulse(0, base, "wr_done_o");
		check_pulse("wr_done_o", 1'b1, wr_pulses == base + 1);
		pack_words(bytes, exp);
		foreach (exp[i])
			expect_rx(exp[i]);
		check_pulse("rx_empty_o", 1'b1, rx_empty);

		// General call, 2 tail bytes dropped
		random_bytes(6, bytes);
		write_trans(i2c_cfg_pkg::GENERAL_CALL_ADDR, bytes, 1'b1, 1'b1);
		pack_words(bytes, exp);
		expect_rx(exp[0]);
		wait_clks(4);
		check_pulse("rx_empty_o", 1'b1, rx_empty);

		// Foreign address, then write with receive full
		base = wr_pulses;
		write_trans(7'h15, bytes, 1'b0, 1'b1);
		wait_clks(40);
		check_pulse("wr_done_o", 1'b0, wr_pulses != base);
		check_pulse("rx_empty_o", 1'b1, rx_empty);
		sent = {};
		for (int n = 0; n < 2; n++) begin
			random_bytes(8, bytes);
			write_trans(OWN, bytes, 1'b1, 1'b1);
			pack_words(bytes, exp);
			sent = {sent, exp};
		end
		wait_clks(20);
		base = wr_pulses;
		write_trans(OWN, bytes, 1'b0, 1'b1);
		wait_clks(40); // wr_done would follow STOP within a few clocks
		check_pulse("wr_done_o", 1'b0, wr_pulses != base);
		foreach (sent[i])
			expect_rx(sent[i]);

		// Read two words
		sent = {};
		for (int n = 0; n < 2; n++) begin
			rand_bits(32, w);
			sent.push_back(w);
			push_tx(w);
		end
		base = rd_pulses;
		read_trans(8, got);
		wait_pulse(1, base, "rd_done_o");
		check_pulse("rd_done_o", 1'b1, rd_pulses == base + 1);
		pack_words(got, exp);
		foreach (sent[i])
			check_word("read word", sent[i], exp[i]);

		// Transmit FIFO now empty, so the read address is refused
		bus_start();
		write_byte({OWN, 1'b1}, ack_n);
		check_ack("empty read address ack", 1'b1, ack_n);
		bus_stop();

		// Master pulls a driven one low
		rand_bits(32, w);
		push_tx(w | 32'h8000_0000);
		base = err_pulses;
		bus_start();
		write_byte({OWN, 1'b1}, ack_n);
		check_ack("read address ack", 1'b0, ack_n);
		write_bit(1'b0);
		wait_pulse(2, base, "rd_err_o");
		check_pulse("rd_err_o", 1'b1, err_pulses == base + 1);
		bus_stop();

		// Repeated START in a write, then a read
		rand_bits(32, w);
		push_tx(w);
		random_bytes(5, bytes);
		base = wr_pulses;
		write_trans(OWN, bytes, 1'b1, 1'b0);
		read_trans(4, got); // Opens with the repeated START
		check_pulse("wr_done_o", 1'b1, wr_pulses == base + 1);
		pack_words(bytes, exp);
		expect_rx(exp[0]);
		pack_words(got, exp);
		check_word("read after restart", w, exp[0]);

		// Transmit FIFO fills at its depth
		for (int n = 0; n < i2c_cfg_pkg::FIFO_DEPTH_DEF; n++) begin
			check_pulse("tx_full_o", 1'b0, tx_full);
			rand_bits(32, w);
			push_tx(w);
		end
		check_pulse("tx_full_o", 1'b1, tx_full);

		wait_clks(20);
		$display("errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
		if (mismatch_cnt == 0 && timeout_cnt == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/i2c_slave_top.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_top #(
	parameter int GLITCH_LEN = i2c_cfg_pkg::GLITCH_LEN_DEF,
	parameter int NEG_DLY    = i2c_cfg_pkg::NEG_DLY_DEF,
	parameter int DEPTH      = i2c_cfg_pkg::FIFO_DEPTH_DEF
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                scl_i,
	input  logic                sda_i,
	output logic                sda_oe_o,
	input  logic [6:0]          own_addr_i,
	input  logic                rx_pop_i,
	output i2c_data_pkg::word_t rx_word_o,
	output logic                rx_empty_o,
	input  logic                tx_push_i,
	input  i2c_data_pkg::word_t tx_word_i,
	output logic                tx_full_o,
	output logic                wr_done_o,
	output logic                rd_done_o,
	output logic                rd_err_o
);

	logic sda_f;
	logic scl_rise;
	logic scl_fall;
	logic start;
	logic stop;
	logic rx_push;
	logic rx_full;
	logic tx_pop;
	logic tx_empty;
	i2c_data_pkg::word_t rx_wdata;
	i2c_data_pkg::word_t tx_head;

	i2c_line_filter #(.GLITCH_LEN(GLITCH_LEN)) u_filter (
		.clk        (clk),
		.rst        (rst),
		.scl_i      (scl_i),
		.sda_i      (sda_i),
		.sda_o      (sda_f),
		.scl_rise_o (scl_rise),
		.scl_fall_o (scl_fall),
		.start_o    (start),
		.stop_o     (stop)
	);

	i2c_slave_engine #(.NEG_DLY(NEG_DLY)) u_engine (
		.clk        (clk),
		.rst        (rst),
		.sda_i      (sda_f),
		.scl_rise_i (scl_rise),
		.scl_fall_i (scl_fall),
		.start_i    (start),
		.stop_i     (stop),
		.own_addr_i (own_addr_i),
		.rx_full_i  (rx_full),
		.tx_empty_i (tx_empty),
		.tx_word_i  (tx_head),
		.sda_oe_o   (sda_oe_o),
		.rx_push_o  (rx_push),
		.tx_pop_o   (tx_pop),
		.rx_word_o  (rx_wdata),
		.wr_done_o  (wr_done_o),
		.rd_done_o  (rd_done_o),
		.rd_err_o   (rd_err_o)
	);

	// Bus to host
	word_fifo #(.DEPTH(DEPTH)) rx_fifo (
		.clk     (clk),
		.rst     (rst),
		.push_i  (rx_push),
		.pop_i   (rx_pop_i),
		.wdata_i (rx_wdata),
		.rdata_o (rx_word_o),
		.full_o  (rx_full),
		.empty_o (rx_empty_o)
	);

	// Host to bus
	word_fifo #(.DEPTH(DEPTH)) tx_fifo (
		.clk     (clk),
		.rst     (rst),
		.push_i  (tx_push_i),
		.pop_i   (tx_pop),
		.wdata_i (tx_word_i),
		.rdata_o (tx_head),
		.full_o  (tx_full_o),
		.empty_o (tx_empty)
	);

endmodule

`default_nettype wire

// File: verilog/word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
	parameter int DEPTH = 4
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                push_i,
	input  logic                pop_i,
	input  i2c_data_pkg::word_t wdata_i,
	output i2c_data_pkg::word_t rdata_o,
	output logic                full_o,
	output logic                empty_o
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	i2c_data_pkg::word_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          do_push;
	logic          do_pop;

	// Out of rule strobes fall away here
	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
			if (do_push && !do_pop)
				count <= count + CW'(1);
			else if (do_pop && !do_push)
				count <= count - CW'(1);
		end
	end

	assign rdata_o = mem[rd_ptr]; // Head word shown ahead
	assign full_o  = count == CW'(DEPTH);
	assign empty_o = count == '0;

endmodule

`default_nettype wire

// File: verilog/i2c_slave_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_engine #(
	parameter int NEG_DLY = 16
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 sda_i,
	input  logic                 scl_rise_i,
	input  logic                 scl_fall_i,
	input  logic                 start_i,
	input  logic                 stop_i,
	input  logic [6:0]           own_addr_i,
	input  logic                 rx_full_i,
	input  logic                 tx_empty_i,
	input  i2c_data_pkg::word_t  tx_word_i,
	output logic                 sda_oe_o,
	output logic                 rx_push_o,
	output logic                 tx_pop_o,
	output i2c_data_pkg::word_t  rx_word_o,
	output logic                 wr_done_o,
	output logic                 rd_done_o,
	output logic                 rd_err_o
);

	localparam int DW  = $clog2(NEG_DLY + 1);
	localparam int BCW = $clog2(i2c_data_pkg::BYTES_PER_WORD);

	i2c_data_pkg::state_t state_q;
	i2c_data_pkg::state_t state_d;
	i2c_data_pkg::word_t  buf_q;
	logic [2:0]     bit_cnt;
	logic [BCW-1:0] byte_cnt;
	logic [DW-1:0]  dly_cnt;
	logic           neg_dly;
	logic           last_bit;
	logic           last_byte;
	logic           start_seen;
	logic           rw_flg;
	logic           addr_ack;
	logic           addr_hit;
	logic           acki_f;
	logic           sda_drv; // 1 releases the line

	assign last_bit  = bit_cnt == 3'd7;
	assign last_byte = byte_cnt == BCW'(i2c_data_pkg::BYTES_PER_WORD - 1);
	assign addr_hit  = (buf_q[7:1] == own_addr_i) ||
		(buf_q[7:1] == i2c_cfg_pkg::GENERAL_CALL_ADDR);

	// ------------------------------
	// Delayed falling edge
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			dly_cnt <= '0;
		else if (scl_fall_i)
			dly_cnt <= DW'(1);
		else if (dly_cnt != '0 && dly_cnt != DW'(NEG_DLY))
			dly_cnt <= dly_cnt + DW'(1);
		else
			dly_cnt <= '0;
	end

	assign neg_dly = dly_cnt == DW'(NEG_DLY);

	always_ff @(posedge clk) begin
		if (rst)
			start_seen <= 1'b0;
		else if (start_i)
			start_seen <= 1'b1;
		else if (scl_fall_i)
			start_seen <= 1'b0; // First fall after START opens the address
	end

	// ------------------------------
	// State machine
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst || start_i || stop_i)
			state_q <= i2c_data_pkg::IDLE;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			i2c_data_pkg::IDLE:
				if (start_seen && scl_fall_i)
					state_d = i2c_data_pkg::ADDR;
			i2c_data_pkg::ADDR:
				if (last_bit && scl_fall_i)
					state_d = i2c_data_pkg::AACKO;
			i2c_data_pkg::AACKO:
				if (scl_fall_i) begin
					if (!addr_ack)
						state_d = i2c_data_pkg::IDLE;
					else if (rw_flg)
						state_d = i2c_data_pkg::DRD;
					else
						state_d = i2c_data_pkg::DWR;
				end
			i2c_data_pkg::DWR:
				if (last_bit && scl_fall_i)
					state_d = i2c_data_pkg::ACKO;
			i2c_data_pkg::ACKO:
				if (scl_fall_i)
					state_d = i2c_data_pkg::DWR;
			i2c_data_pkg::DRD:
				if (scl_rise_i && sda_i != sda_drv)
					state_d = i2c_data_pkg::IDLE; // Lost the line
				else if (last_bit && scl_fall_i)
					state_d = i2c_data_pkg::ACKI;
			i2c_data_pkg::ACKI:
				if (scl_fall_i)
					state_d = acki_f ? i2c_data_pkg::IDLE : i2c_data_pkg::DRD;
			default:
				state_d = i2c_data_pkg::IDLE;
		endcase
	end

	// ------------------------------
	// Bit and byte counters
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst || state_q == i2c_data_pkg::IDLE)
			bit_cnt <= 3'd0;
		else if (scl_fall_i && (state_q == i2c_data_pkg::ADDR ||
				state_q == i2c_data_pkg::DWR || state_q == i2c_data_pkg::DRD))
			bit_cnt <= bit_cnt + 3'd1; // Wraps to 0 on the byte end
	end

	always_ff @(posedge clk) begin
		if (rst || state_q == i2c_data_pkg::IDLE)
			byte_cnt <= '0;
		else if (last_bit && scl_fall_i && (state_q == i2c_data_pkg::DWR ||
				state_q == i2c_data_pkg::DRD))
			byte_cnt <= last_byte ? '0 : byte_cnt + BCW'(1);
	end

	// Address decision at the end of the address byte
	always_ff @(posedge clk) begin
		if (rst) begin
			rw_flg   <= 1'b0;
			addr_ack <= 1'b0;
		end else if (state_q == i2c_data_pkg::ADDR && last_bit && scl_fall_i) begin
			rw_flg   <= buf_q[0];
			addr_ack <= addr_hit && (buf_q[0] ? ~tx_empty_i : ~rx_full_i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			acki_f <= 1'b1;
		else if (state_q == i2c_data_pkg::ACKI && scl_rise_i)
			acki_f <= sda_i; // High means master NACK
	end

	// ------------------------------
	// SDA drive
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst || state_q == i2c_data_pkg::IDLE)
			sda_drv <= 1'b1;
		else if (neg_dly) begin
			case (state_q)
				i2c_data_pkg::AACKO: sda_drv <= ~addr_ack;
				i2c_data_pkg::ACKO:  sda_drv <= 1'b0;
				i2c_data_pkg::DRD:   sda_drv <= buf_q[31];
				default:             sda_drv <= 1'b1;
			endcase
		end
	end

	assign sda_oe_o = ~sda_drv;

	// Shift in on address and write, out on read, reload on pop
	always_ff @(posedge clk) begin
		if (tx_pop_o)
			buf_q <= tx_word_i;
		else if (scl_rise_i && state_q == i2c_data_pkg::DRD)
			buf_q <= {buf_q[30:0], 1'b0};
		else if (scl_rise_i && (state_q == i2c_data_pkg::ADDR ||
				state_q == i2c_data_pkg::DWR))
			buf_q <= {buf_q[30:0], sda_i};
	end

	assign rx_word_o = buf_q;

	// ------------------------------
	// FIFO strobes and status
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_push_o <= 1'b0;
			tx_pop_o  <= 1'b0;
			wr_done_o <= 1'b0;
			rd_done_o <= 1'b0;
			rd_err_o  <= 1'b0;
		end else begin
			rx_push_o <= state_q == i2c_data_pkg::DWR && last_bit && scl_fall_i && last_byte;
			tx_pop_o  <= scl_rise_i && ~tx_empty_i &&
				((state_q == i2c_data_pkg::AACKO && addr_ack && rw_flg) ||
				(state_q == i2c_data_pkg::ACKI && ~sda_i && byte_cnt == '0));
			wr_done_o <= state_q == i2c_data_pkg::DWR && (start_i || stop_i);
			rd_done_o <= state_q == i2c_data_pkg::ACKI && scl_fall_i && acki_f;
			rd_err_o  <= state_q == i2c_data_pkg::DRD && scl_rise_i && sda_i != sda_drv;
		end
	end

endmodule

`default_nettype wire

// File: verilog/i2c_line_filter.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_line_filter #(
	parameter int GLITCH_LEN = 6
) (
	input  logic clk,
	input  logic rst,
	input  logic scl_i,
	input  logic sda_i,
	output logic sda_o,
	output logic scl_rise_o,
	output logic scl_fall_o,
	output logic start_o,
	output logic stop_o
);

	logic [GLITCH_LEN-1:0] scl_f;
	logic [GLITCH_LEN-1:0] sda_f;
	logic [3:0] scl_old;
	logic [3:0] sda_old;
	logic scl_q;
	logic scl_r;
	logic sda_q;
	logic sda_r;

	// Sample chains, idle bus reads high
	always_ff @(posedge clk) begin
		if (rst) begin
			scl_f <= '1;
			sda_f <= '1;
		end else begin
			scl_f <= {scl_f[GLITCH_LEN-2:0], scl_i};
			sda_f <= {sda_f[GLITCH_LEN-2:0], sda_i};
		end
	end

	assign scl_old = scl_f[GLITCH_LEN-1 -: 4];
	assign sda_old = sda_f[GLITCH_LEN-1 -: 4];

	// ------------------------------
	// Filtered levels
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			scl_q <= 1'b1;
			sda_q <= 1'b1;
			scl_r <= 1'b1;
			sda_r <= 1'b1;
		end else begin
			if (&scl_old)
				scl_q <= 1'b1;
			else if (~|scl_old)
				scl_q <= 1'b0; // Mixed samples hold the old level
			if (&sda_old)
				sda_q <= 1'b1;
			else if (~|sda_old)
				sda_q <= 1'b0;
			scl_r <= scl_q;
			sda_r <= sda_q;
		end
	end

	assign sda_o      = sda_q;
	assign scl_rise_o = scl_q & ~scl_r;
	assign scl_fall_o = ~scl_q & scl_r;
	// SDA moves while SCL stays high
	assign start_o    = scl_q & scl_r & sda_r & ~sda_q;
	assign stop_o     = scl_q & scl_r & ~sda_r & sda_q;

endmodule

`default_nettype wire

// File: verilog/i2c_data_pkg.sv
`default_nettype none

package i2c_data_pkg;

	// First byte on the bus sits in bits 31:24
	typedef logic [31:0] word_t;

	localparam int BYTES_PER_WORD = 4;

	// Byte engine states
	typedef enum logic [2:0] {
		IDLE  = 3'd0,
		ADDR  = 3'd1, // Address byte coming in
		DWR   = 3'd2, // Write data from master
		DRD   = 3'd3, // Read data to master
		ACKO  = 3'd4, // Our ACK after a data byte
		AACKO = 3'd5, // Our ACK or NACK after the address
		ACKI  = 3'd6  // Master ACK after read byte
	} state_t;

endpackage

`default_nettype wire

// File: verilog/i2c_cfg_pkg.sv
`default_nettype none

// ------------------------------
// Bus timing and addressing
// ------------------------------
package i2c_cfg_pkg;

	// Pin sample chain length, oldest four samples must agree
	localparam int GLITCH_LEN_DEF = 6;

	// Clocks from SCL fall to SDA drive change
	localparam int NEG_DLY_DEF = 16;

	// Words per FIFO
	localparam int FIFO_DEPTH_DEF = 4;

	// Broadcast address, answered next to the own address
	localparam logic [6:0] GENERAL_CALL_ADDR = 7'h00;

endpackage

`default_nettype wire
